//--- compile.f
hdl/afuPkg.sv
hdl/readOrderBuffer.sv
hdl/writeTracker.sv
hdl/copyEngine.sv
hdl/mmioCsr.sv
hdl/ccipAfuTop.sv
sim/hostMemModel.sv
sim/tbCcipAfu.sv

//--- Makefile
# Verilator build and run for the line copy AFU

VERILATOR ?= verilator
TOP       ?= tbCcipAfu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep '\.s\?v$$' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuild only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tbCcipAfu.sv
//==========================================================================
// Testbench for the line copy AFU
// Drives MMIO, runs copies against the host memory model and checks
// every destination line against the fill pattern of its source line
//==========================================================================

`timescale 1ns/1ns

module tbCcipAfu;
  import afuPkg::*;

  // Lines copied over the whole run set the cycle limit
  localparam int totalLines   = 5 + 40 + 0;
  localparam int timeoutLimit = totalLines * 20 + 2000;

  logic      pClk;
  logic      rst;
  logic      mmioWrValid;
  logic      mmioRdValid;
  mmioAddrT  mmioAddr;
  mmioDataT  mmioWrData;
  logic      mmioRspValid;
  mmioDataT  mmioRspData;
  logic      c0TxValid;
  lineAddrT  c0TxAddr;
  mdataT     c0TxMdata;
  logic      c0RxValid;
  mdataT     c0RxMdata;
  lineDataT  c0RxData;
  logic      c0TxAlmFull;
  logic      c1TxValid;
  lineAddrT  c1TxAddr;
  lineDataT  c1TxData;
  logic      c1RxValid;
  logic      c1TxAlmFull;
  logic      backPressure;
  logic [63:0] patternKey;

  // Copy in progress, as seen by the read and write monitor
  lineAddrT  copySrc;
  lineAddrT  copyDst;
  lineCountT copyLines;

  // Every line the AFU wrote, by address
  lineDataT  seenWrites [lineAddrT];
  int        writesSeen;
  int        errorCount;
  int        cycleTotal;

  ccipAfuTop ccipAfuTop_i (
    .pClk, .rst, .mmioWrValid, .mmioRdValid, .mmioAddr, .mmioWrData,
    .mmioRspValid, .mmioRspData, .c0TxValid, .c0TxAddr, .c0TxMdata,
    .c0RxValid, .c0RxMdata, .c0RxData, .c0TxAlmFull,
    .c1TxValid, .c1TxAddr, .c1TxData, .c1RxValid, .c1TxAlmFull
  );

  hostMemModel hostMemModel_i (
    .pClk, .rst, .backPressure, .patternKey, .c0TxValid, .c0TxAddr, .c0TxMdata,
    .c0RxValid, .c0RxMdata, .c0RxData, .c0TxAlmFull,
    .c1TxValid, .c1TxAddr, .c1TxData, .c1RxValid, .c1TxAlmFull
  );

  initial
  begin
    pClk = 1'b0;
    forever #2 pClk = ~pClk;
  end

  //==========================================================================
  // Reference, compare and bus helpers
  //==========================================================================

  // A copied line must hold the fill pattern of its source line
  function automatic lineDataT expectedLine(lineAddrT srcAddr);
    return {srcAddr ^ patternKey[63:32], (srcAddr * 32'h9E37_79B1) ^ patternKey[31:0]};
  endfunction

  task automatic compareValues(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
    if (got !== expected)
    begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  // Leaves the caller 1 ns past a rising edge, where inputs change
  task automatic idleCycles(input int n);
    repeat (n) @(posedge pClk);
    #1;
  endtask

  task automatic writeReg(input mmioAddrT addr, input mmioDataT data);
    mmioAddr    = addr;
    mmioWrData  = data;
    mmioWrValid = 1'b1;
    idleCycles(1);
    mmioWrValid = 1'b0;
  endtask

  task automatic readReg(input mmioAddrT addr, output mmioDataT data);
    mmioAddr    = addr;
    mmioRdValid = 1'b1;
    idleCycles(1);
    mmioRdValid = 1'b0;
    while (!mmioRspValid)
      idleCycles(1);
    data = mmioRspData;
  endtask

  // Programs one copy, waits for done and checks the destination lines
  task automatic runCopy(input lineAddrT src, input lineAddrT dst, input lineCountT lines,
                         input logic pressure, input logic restartWhileBusy);
    mmioDataT status;
    mmioDataT cycles;
    lineAddrT dstLine;
    int       writesBefore;
    copySrc      = src;
    copyDst      = dst;
    copyLines    = lines;
    backPressure = pressure;
    writesBefore = writesSeen;
    writeReg(regSrc, mmioDataT'(src));
    writeReg(regDst, mmioDataT'(dst));
    writeReg(regLines, mmioDataT'(lines));
    writeReg(regCtrl, 64'd1);
    // Start reaches the engine two edges after the write, so status is fresh after that
    idleCycles(2);
    if (restartWhileBusy)
    begin
      readReg(regStatus, status);
      compareValues(64'(status[1]), 64'd1, "busy bit during copy");
      writeReg(regLines, 64'd3);
      writeReg(regCtrl, 64'd1);
    end
    status = '0;
    while (status[0] == 1'b0)
      readReg(regStatus, status);
    compareValues(64'(status[1:0]), 64'd1, "status after copy");
    readReg(regCycles, cycles);
    if (lines == '0)
      compareValues(cycles, 64'd0, "cycle count of empty copy");
    else
      compareValues(64'(cycles != '0), 64'd1, "cycle count is nonzero");
    compareValues(64'(writesSeen - writesBefore), 64'(lines), "number of lines written");
    for (int i = 0; i < int'(lines); i++)
    begin
      dstLine = dst + lineAddrT'(i);
      if (!seenWrites.exists(dstLine))
      begin
        $display("ERROR at %0t: destination line %h was never written", $time, dstLine);
        errorCount++;
      end
      else
        compareValues(seenWrites[dstLine], expectedLine(src + lineAddrT'(i)),
                      $sformatf("destination line %0d", i));
    end
    backPressure = 1'b0;
  endtask

  //==========================================================================
  // Read and write monitor and timeout
  //==========================================================================

  // Flags any read outside the source range, records each write and
  // flags any write that misses the destination range
  always @(negedge pClk)
  begin
    lineAddrT offset;
    if (!rst && c0TxValid)
    begin
      offset = c0TxAddr - copySrc;
      if (offset >= lineAddrT'(copyLines))
      begin
        $display("ERROR at %0t: read of line %h lies outside the source range",
                 $time, c0TxAddr);
        errorCount++;
      end
    end
    if (!rst && c1TxValid)
    begin
      offset = c1TxAddr - copyDst;
      if (offset >= lineAddrT'(copyLines))
      begin
        $display("ERROR at %0t: write to line %h lies outside the destination range",
                 $time, c1TxAddr);
        errorCount++;
      end
      seenWrites[c1TxAddr] = c1TxData;
      writesSeen++;
    end
  end

  always @(posedge pClk)
  begin
    cycleTotal++;
    if (cycleTotal >= timeoutLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
      $display("TB FAILED");
      $finish;
    end
  end

  //==========================================================================
  // Test sequence
  //==========================================================================

  initial
  begin
    mmioDataT rdValue;
    rst          = 1'b1;
    mmioWrValid  = 1'b0;
    mmioRdValid  = 1'b0;
    mmioAddr     = '0;
    mmioWrData   = '0;
    backPressure = 1'b0;
    copySrc      = '0;
    copyDst      = '0;
    copyLines    = '0;
    writesSeen   = 0;
    errorCount   = 0;
    cycleTotal   = 0;
    void'($urandom(33));
    patternKey   = {$urandom, $urandom};
    repeat (8) @(posedge pClk);
    #1;
    rst = 1'b0;
    idleCycles(2);

    // Feature header and an offset past the register map
    readReg(regFeature, rdValue);
    compareValues(rdValue, afuFeatureId, "feature header");
    readReg(16'h0040, rdValue);
    compareValues(rdValue, 64'd0, "unknown offset");

    // Parameter registers read back what was written
    writeReg(regSrc, 64'h0000_0000_00AB_C123);
    writeReg(regDst, 64'h0000_0000_0DEF_0456);
    writeReg(regLines, 64'h0000_0000_0000_1234);
    readReg(regSrc, rdValue);
    compareValues(rdValue, 64'h0000_0000_00AB_C123, "regSrc readback");
    readReg(regDst, rdValue);
    compareValues(rdValue, 64'h0000_0000_0DEF_0456, "regDst readback");
    readReg(regLines, rdValue);
    compareValues(rdValue, 64'h0000_0000_0000_1234, "regLines readback");

    // Short copy, then a long one under back-pressure with a start while busy
    runCopy(32'h0000_1000, 32'h0008_0000, 16'd5, 1'b0, 1'b0);
    runCopy(32'h0000_2000, 32'h0009_0000, 16'd40, 1'b1, 1'b1);
    runCopy(32'h0000_3000, 32'h000A_0000, 16'd0, 1'b0, 1'b0);

    idleCycles(4);
    $display("Errors: %0d", errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- sim/hostMemModel.sv
//==========================================================================
// Host memory model for the line copy AFU
// Serves tagged reads out of order after random delays, stores writes,
// acks them late and raises both almost-full levels at random
//==========================================================================

`timescale 1ns/1ns

module hostMemModel (
  input  logic             pClk,
  input  logic             rst,
  input  logic             backPressure,
  input  logic [63:0]      patternKey,
  input  logic             c0TxValid,
  input  afuPkg::lineAddrT c0TxAddr,
  input  afuPkg::mdataT    c0TxMdata,
  output logic             c0RxValid,
  output afuPkg::mdataT    c0RxMdata,
  output afuPkg::lineDataT c0RxData,
  output logic             c0TxAlmFull,
  input  logic             c1TxValid,
  input  afuPkg::lineAddrT c1TxAddr,
  input  afuPkg::lineDataT c1TxData,
  output logic             c1RxValid,
  output logic             c1TxAlmFull
);
  import afuPkg::*;

  // Lines written by the AFU; every other line holds the fill pattern
  lineDataT wrMem [lineAddrT];

  // Reads waiting for their response cycle, one entry per request
  int       rdDue [$];
  mdataT    rdTag [$];
  lineAddrT rdLine [$];

  // Cycles at which the pending write acks become due
  int       ackDue [$];
  int       cyc;

  // Fill pattern, a mix of the whole line address and the run's key
  function automatic lineDataT fillPattern(lineAddrT addr);
    return {addr ^ patternKey[63:32], (addr * 32'h9E37_79B1) ^ patternKey[31:0]};
  endfunction

  //==========================================================================
  // One step per cycle, 1 ns after the rising edge
  //==========================================================================

  initial
  begin
    int pick;
    c0RxValid   = 1'b0;
    c0RxMdata   = '0;
    c0RxData    = '0;
    c0TxAlmFull = 1'b0;
    c1RxValid   = 1'b0;
    c1TxAlmFull = 1'b0;
    cyc         = 0;
    forever
    begin
      @(posedge pClk);
      #1;
      cyc++;
      c0RxValid = 1'b0;
      c1RxValid = 1'b0;
      if (rst)
      begin
        rdDue.delete();
        rdTag.delete();
        rdLine.delete();
        ackDue.delete();
        c0TxAlmFull = 1'b0;
        c1TxAlmFull = 1'b0;
      end
      else
      begin
        // Each read gets its own delay of 1 to 8 cycles
        if (c0TxValid)
        begin
          rdDue.push_back(cyc + int'($urandom_range(1, 8)));
          rdTag.push_back(c0TxMdata);
          rdLine.push_back(c0TxAddr);
        end
        if (c1TxValid)
        begin
          wrMem[c1TxAddr] = c1TxData;
          ackDue.push_back(cyc + int'($urandom_range(1, 6)));
        end
        // The oldest read that is due answers; younger short delays overtake
        pick = -1;
        foreach (rdDue[k])
        begin
          if (pick < 0 && rdDue[k] <= cyc)
            pick = k;
        end
        if (pick >= 0)
        begin
          c0RxValid = 1'b1;
          c0RxMdata = rdTag[pick];
          c0RxData  = wrMem.exists(rdLine[pick]) ? wrMem[rdLine[pick]]
                                                 : fillPattern(rdLine[pick]);
          rdDue.delete(pick);
          rdTag.delete(pick);
          rdLine.delete(pick);
        end
        // Acks carry no tag, so at most one due ack goes out per cycle
        pick = -1;
        foreach (ackDue[k])
        begin
          if (pick < 0 && ackDue[k] <= cyc)
            pick = k;
        end
        if (pick >= 0)
        begin
          c1RxValid = 1'b1;
          ackDue.delete(pick);
        end
        c0TxAlmFull = backPressure && ($urandom_range(0, 3) == 0);
        c1TxAlmFull = backPressure && ($urandom_range(0, 3) == 0);
      end
    end
  end

endmodule

//--- hdl/ccipAfuTop.sv
//==========================================================================
// Line copy AFU top level
// Joins the MMIO registers, the read order buffer, the write tracker
// and the copy engine to the host MMIO, read and write channels
//==========================================================================

`timescale 1ns/1ns

module ccipAfuTop #(
  parameter int robDepth = 8
) (
  input  logic             pClk,
  input  logic             rst,
  // MMIO from the host
  input  logic             mmioWrValid,
  input  logic             mmioRdValid,
  input  afuPkg::mmioAddrT mmioAddr,
  input  afuPkg::mmioDataT mmioWrData,
  output logic             mmioRspValid,
  output afuPkg::mmioDataT mmioRspData,
  // Host read channel
  output logic             c0TxValid,
  output afuPkg::lineAddrT c0TxAddr,
  output afuPkg::mdataT    c0TxMdata,
  input  logic             c0RxValid,
  input  afuPkg::mdataT    c0RxMdata,
  input  afuPkg::lineDataT c0RxData,
  input  logic             c0TxAlmFull,
  // Host write channel
  output logic             c1TxValid,
  output afuPkg::lineAddrT c1TxAddr,
  output afuPkg::lineDataT c1TxData,
  input  logic             c1RxValid,
  input  logic             c1TxAlmFull
);
  import afuPkg::*;

  lineAddrT  srcBase, dstBase, rdAddr, wrAddr;
  lineCountT numLines, wrDoneCount;
  lineDataT  sortData, wrData;
  mmioDataT  cycleCount;
  logic      startPulse, busy, doneFlag;
  logic      rdIssue, slotFree, sortReady, sortValid, wrIssue;

  mmioCsr mmioCsr_i (
    .pClk, .rst, .mmioWrValid, .mmioRdValid, .mmioAddr, .mmioWrData,
    .busy, .doneFlag, .cycleCount, .mmioRspValid, .mmioRspData,
    .srcBase, .dstBase, .numLines, .startPulse
  );

  readOrderBuffer #(.robDepth(robDepth)) readOrderBuffer_i (
    .pClk, .rst, .rdIssue, .rdAddr, .sortReady, .c0RxValid, .c0RxMdata,
    .c0RxData, .slotFree, .c0TxValid, .c0TxAddr, .c0TxMdata, .sortValid, .sortData
  );

  writeTracker writeTracker_i (
    .pClk, .rst, .startPulse, .wrIssue, .wrAddr, .wrData, .c1RxValid,
    .c1TxValid, .c1TxAddr, .c1TxData, .wrDoneCount
  );

  copyEngine copyEngine_i (
    .pClk, .rst, .startPulse, .srcBase, .dstBase, .numLines, .slotFree,
    .c0TxAlmFull, .c1TxAlmFull, .sortValid, .sortData, .wrDoneCount,
    .rdIssue, .rdAddr, .sortReady, .wrIssue, .wrAddr, .wrData,
    .busy, .doneFlag, .cycleCount
  );

endmodule

//--- hdl/mmioCsr.sv
//==========================================================================
// MMIO register file
// Feature header, copy parameters, start control, status and cycle
// count, with every read answered one cycle later
//==========================================================================

`timescale 1ns/1ns

module mmioCsr (
  input  logic              pClk,
  input  logic              rst,
  input  logic              mmioWrValid,
  input  logic              mmioRdValid,
  input  afuPkg::mmioAddrT  mmioAddr,
  input  afuPkg::mmioDataT  mmioWrData,
  input  logic              busy,
  input  logic              doneFlag,
  input  afuPkg::mmioDataT  cycleCount,
  output logic              mmioRspValid,
  output afuPkg::mmioDataT  mmioRspData,
  output afuPkg::lineAddrT  srcBase,
  output afuPkg::lineAddrT  dstBase,
  output afuPkg::lineCountT numLines,
  output logic              startPulse
);
  import afuPkg::*;

  mmioDataT rdMux;

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      srcBase      <= '0;
      dstBase      <= '0;
      numLines     <= '0;
      startPulse   <= 1'b0;
      mmioRspValid <= 1'b0;
    end
    else
    begin
      mmioRspValid <= mmioRdValid;
      // A start during a copy is dropped here so that no block sees it
      startPulse   <= mmioWrValid && (mmioAddr == regCtrl) && mmioWrData[0] && !busy;
      if (mmioWrValid)
      begin
        case (mmioAddr)
          regSrc:   srcBase  <= lineAddrT'(mmioWrData);
          regDst:   dstBase  <= lineAddrT'(mmioWrData);
          regLines: numLines <= lineCountT'(mmioWrData);
          default:  ;
        endcase
      end
    end
  end

  // Read decode; status carries done in bit 0 and busy in bit 1
  always_comb
  begin
    case (mmioAddr)
      regFeature: rdMux = afuFeatureId;
      regSrc:     rdMux = mmioDataT'(srcBase);
      regDst:     rdMux = mmioDataT'(dstBase);
      regLines:   rdMux = mmioDataT'(numLines);
      regStatus:  rdMux = {62'b0, busy, doneFlag};
      regCycles:  rdMux = cycleCount;
      default:    rdMux = '0;
    endcase
  end

  always_ff @(posedge pClk)
  begin
    if (mmioRdValid)
      mmioRspData <= rdMux;
  end

endmodule

//--- hdl/copyEngine.sv
//==========================================================================
// Copy engine
// Issues the source reads, forwards each sorted line as a write to the
// destination and waits for every write ack before flagging done
//==========================================================================

`timescale 1ns/1ns

module copyEngine (
  input  logic              pClk,
  input  logic              rst,
  input  logic              startPulse,
  input  afuPkg::lineAddrT  srcBase,
  input  afuPkg::lineAddrT  dstBase,
  input  afuPkg::lineCountT numLines,
  input  logic              slotFree,
  input  logic              c0TxAlmFull,
  input  logic              c1TxAlmFull,
  input  logic              sortValid,
  input  afuPkg::lineDataT  sortData,
  input  afuPkg::lineCountT wrDoneCount,
  output logic              rdIssue,
  output afuPkg::lineAddrT  rdAddr,
  output logic              sortReady,
  output logic              wrIssue,
  output afuPkg::lineAddrT  wrAddr,
  output afuPkg::lineDataT  wrData,
  output logic              busy,
  output logic              doneFlag,
  output afuPkg::mmioDataT  cycleCount
);
  import afuPkg::*;

  copyStateT state;

  // Copy parameters captured at start
  lineAddrT  srcReg;
  lineAddrT  dstReg;
  lineCountT linesReg;

  // Lines read so far and lines written so far
  lineCountT rdIdx;
  lineCountT wrIdx;
  logic      lastWrite;

  // Reads stop at the line count, at a full order buffer or at host back-pressure
  assign rdIssue   = (state == run) && (rdIdx != linesReg) && slotFree && !c0TxAlmFull;
  assign rdAddr    = srcReg + lineAddrT'(rdIdx);
  assign sortReady = !c1TxAlmFull;

  // Sorted lines turn into writes in the same cycle
  assign wrIssue   = sortValid;
  assign wrAddr    = dstReg + lineAddrT'(wrIdx);
  assign wrData    = sortData;
  assign lastWrite = wrIssue && (wrIdx == linesReg - 1'b1);

  //==========================================================================
  // Copy FSM
  //==========================================================================

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      state      <= idle;
      rdIdx      <= '0;
      wrIdx      <= '0;
      busy       <= 1'b0;
      doneFlag   <= 1'b0;
      cycleCount <= '0;
    end
    else
    begin
      if (busy)
        cycleCount <= cycleCount + 1'b1;
      if (rdIssue)
        rdIdx <= rdIdx + 1'b1;
      if (wrIssue)
        wrIdx <= wrIdx + 1'b1;
      case (state)
        idle, done:
        begin
          if (startPulse)
          begin
            doneFlag   <= 1'b0;
            cycleCount <= '0;
            rdIdx      <= '0;
            wrIdx      <= '0;
            // An empty copy has nothing to wait for
            if (numLines == '0)
            begin
              doneFlag <= 1'b1;
              state    <= done;
            end
            else
            begin
              busy  <= 1'b1;
              state <= run;
            end
          end
          else if (state == done)
            state <= idle;
        end
        run:
        begin
          if (lastWrite)
            state <= drain;
        end
        drain:
        begin
          // All writes are issued; wait for the host to ack the last one
          if (wrDoneCount == linesReg)
          begin
            busy     <= 1'b0;
            doneFlag <= 1'b1;
            state    <= done;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Parameters are captured at start and held for the whole copy
  always_ff @(posedge pClk)
  begin
    if (startPulse && (state == idle || state == done))
    begin
      srcReg   <= srcBase;
      dstReg   <= dstBase;
      linesReg <= numLines;
    end
  end

  // The order buffer can only release lines that this FSM asked for
  writeOutsideRun: assert property (@(posedge pClk) disable iff (rst)
    wrIssue |-> (state == run))
    else $error("sorted line arrived outside a running copy");

endmodule

//--- hdl/writeTracker.sv
//==========================================================================
// Write tracker
// Registers write requests onto the host write channel and counts
// the requests in flight and the acks received
//==========================================================================

`timescale 1ns/1ns

module writeTracker (
  input  logic              pClk,
  input  logic              rst,
  input  logic              startPulse,
  input  logic              wrIssue,
  input  afuPkg::lineAddrT  wrAddr,
  input  afuPkg::lineDataT  wrData,
  input  logic              c1RxValid,
  output logic              c1TxValid,
  output afuPkg::lineAddrT  c1TxAddr,
  output afuPkg::lineDataT  c1TxData,
  output afuPkg::lineCountT wrDoneCount
);
  import afuPkg::*;

  // Writes issued but not yet acked by the host
  lineCountT outstanding;

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      c1TxValid   <= 1'b0;
      outstanding <= '0;
      wrDoneCount <= '0;
    end
    else
    begin
      c1TxValid <= wrIssue;
      // Both counters restart with each copy
      if (startPulse)
      begin
        outstanding <= '0;
        wrDoneCount <= '0;
      end
      else
      begin
        outstanding <= outstanding + lineCountT'(wrIssue) - lineCountT'(c1RxValid);
        if (c1RxValid)
          wrDoneCount <= wrDoneCount + 1'b1;
      end
    end
  end

  // Address and data only matter while c1TxValid is high
  always_ff @(posedge pClk)
  begin
    c1TxAddr <= wrAddr;
    c1TxData <= wrData;
  end

  // An ack with nothing in flight means the host invented a write
  ackWithoutWrite: assert property (@(posedge pClk) disable iff (rst)
    c1RxValid |-> (outstanding != '0))
    else $error("write ack with no write outstanding");

endmodule

//--- hdl/readOrderBuffer.sv
//==========================================================================
// Read order buffer
// Tags each host read with a slot number, parks the out-of-order
// responses in their slots and hands the data on in request order
//==========================================================================

`timescale 1ns/1ns

module readOrderBuffer #(
  parameter int robDepth = 8
) (
  input  logic             pClk,
  input  logic             rst,
  input  logic             rdIssue,
  input  afuPkg::lineAddrT rdAddr,
  input  logic             sortReady,
  input  logic             c0RxValid,
  input  afuPkg::mdataT    c0RxMdata,
  input  afuPkg::lineDataT c0RxData,
  output logic             slotFree,
  output logic             c0TxValid,
  output afuPkg::lineAddrT c0TxAddr,
  output afuPkg::mdataT    c0TxMdata,
  output logic             sortValid,
  output afuPkg::lineDataT sortData
);
  import afuPkg::*;

  localparam int idxW = $clog2(robDepth);
  localparam logic [idxW:0] slotsTotal = (idxW + 1)'(robDepth);

  // Slot storage, written by tag and read at the head
  lineDataT dataMem [robDepth];

  // A slot is pending from issue until release, filled once its data is in
  logic [robDepth-1:0] pending;
  logic [robDepth-1:0] filled;
  logic [idxW-1:0]     headPtr;
  logic [idxW-1:0]     tailPtr;
  logic [idxW-1:0]     rxIdx;
  logic [idxW:0]       inFlight;
  logic                headHit;
  logic                headRelease;

  assign rxIdx = c0RxMdata[idxW-1:0];

  // A response for the head slot goes straight out without waiting a cycle
  assign headHit     = c0RxValid && (rxIdx == headPtr);
  assign headRelease = sortReady && (filled[headPtr] || headHit);
  assign slotFree    = (inFlight != slotsTotal);

  //==========================================================================
  // Pointers, slot flags and strobes
  //==========================================================================

  always_ff @(posedge pClk)
  begin
    if (rst)
    begin
      headPtr   <= '0;
      tailPtr   <= '0;
      inFlight  <= '0;
      pending   <= '0;
      filled    <= '0;
      c0TxValid <= 1'b0;
      sortValid <= 1'b0;
    end
    else
    begin
      c0TxValid <= rdIssue;
      sortValid <= headRelease;
      if (rdIssue)
      begin
        tailPtr          <= tailPtr + 1'b1;
        pending[tailPtr] <= 1'b1;
      end
      // A head response that leaves at once never marks its slot filled
      if (c0RxValid && !(headHit && headRelease))
        filled[rxIdx] <= 1'b1;
      if (headRelease)
      begin
        headPtr          <= headPtr + 1'b1;
        filled[headPtr]  <= 1'b0;
        pending[headPtr] <= 1'b0;
      end
      inFlight <= inFlight + (idxW + 1)'(rdIssue) - (idxW + 1)'(headRelease);
    end
  end

  // Request fields and slot data are qualified by the strobes above
  always_ff @(posedge pClk)
  begin
    c0TxAddr  <= rdAddr;
    c0TxMdata <= mdataT'(tailPtr);
    if (c0RxValid)
      dataMem[rxIdx] <= c0RxData;
    if (headRelease)
      sortData <= filled[headPtr] ? dataMem[headPtr] : c0RxData;
  end

  //==========================================================================
  // Checks on the engine and the host
  //==========================================================================

  // The copy engine must respect the free-slot level
  issueWhileFull: assert property (@(posedge pClk) disable iff (rst)
    rdIssue |-> slotFree)
    else $error("read issued with every slot in use");

  // The host may only answer a tag that is waiting for its data
  strayResponse: assert property (@(posedge pClk) disable iff (rst)
    c0RxValid |-> (pending[rxIdx] && !filled[rxIdx]))
    else $error("read response for a slot that is not outstanding");

endmodule

//--- hdl/afuPkg.sv
//==========================================================================
// Shared definitions for the line copy AFU
// Vector types for addresses, data, tags and counts, the copy FSM
// states and the MMIO register map
//==========================================================================

package afuPkg;

  // Host cache-line address, in units of whole lines
  typedef logic [31:0] lineAddrT;

  // One line of payload, narrowed to 64 bits
  typedef logic [63:0] lineDataT;

  // Read request tag; the order buffer only looks at its low bits
  typedef logic [7:0] mdataT;

  // Number of lines in a copy, and the counters that walk it
  typedef logic [15:0] lineCountT;

  // MMIO byte offset and data word
  typedef logic [15:0] mmioAddrT;
  typedef logic [63:0] mmioDataT;

  // Copy engine states
  typedef enum logic [1:0] {
    idle,
    run,
    drain,
    done
  } copyStateT;

  //==========================================================================
  // MMIO register map
  //==========================================================================

  localparam mmioAddrT regFeature = 16'h0000;
  localparam mmioAddrT regSrc     = 16'h0008;
  localparam mmioAddrT regDst     = 16'h0010;
  localparam mmioAddrT regLines   = 16'h0018;
  localparam mmioAddrT regCtrl    = 16'h0020;
  localparam mmioAddrT regStatus  = 16'h0028;
  localparam mmioAddrT regCycles  = 16'h0030;

  // Value returned by the feature header at offset 0
  localparam mmioDataT afuFeatureId = 64'h1000_0000_C0B7_0001;

endpackage
